/* corePkg.sv */
package corePkg;

   // Word address width on the memory bus
   localparam int addrBits = 10;

   // One request on the shared memory port
   typedef struct packed {
      logic valid;
      logic [addrBits-1:0] addr;
      logic write;
      isaPkg::word data;
   } memRequest;

   // Read word, one cycle after a granted read
   typedef struct packed {
      isaPkg::word data;
   } memResponse;

   // Control for the execute stage
   typedef struct packed {
      isaPkg::aluOp alu;
      logic useImm;
      logic useShamt;
      isaPkg::regAddr dest;
      logic regWrite;
      logic load;
      logic store;
      logic beq;
      logic bne;
      logic jump;
      isaPkg::word imm;
      logic [4:0] shamt;
      // Raw instr[25:0], rs and rt sit in its top ten bits
      logic [25:0] target;
   } decoded;

   // Execute pipeline register
   typedef struct packed {
      logic valid;
      decoded ctrl;
      isaPkg::word opA;
      isaPkg::word opB;
      isaPkg::word pc;
   } execBundle;

   typedef struct packed {
      logic valid;
      isaPkg::regAddr dest;
      isaPkg::word result;
      logic load;
   } wbBundle;

   // Register write, also the retire report
   typedef struct packed {
      logic valid;
      isaPkg::regAddr dest;
      isaPkg::word data;
   } retire;

endpackage

/* cpuTb.sv */
module cpuTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int progLen = 31;
   localparam int retireTimeout = 200;
   localparam int quietCycles = 50;

   // One program word and the retire it must produce
   typedef struct packed {
      isaPkg::word instr;
      logic retires;
      isaPkg::regAddr dest;
      isaPkg::word value;
   } progRow;

   logic clk;
   logic reset;
   logic hold;
   logic runDone;
   corePkg::memRequest hostWrite;
   corePkg::retire retireOut;
   progRow prog [progLen];

   cpuTop #(.memWords(1024)) UUT (
      .clk(clk), .reset(reset), .hold(hold), .hostWrite(hostWrite), .retireOut(retireOut)
   );

   always #2 clk = ~clk;

   // I-type word from operands in assembly order rt, rs
   function automatic isaPkg::word encodeI(input isaPkg::opcode op, input isaPkg::regAddr rt,
                                           input isaPkg::regAddr rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // R-type word from operands in assembly order rd, rs, rt
   function automatic isaPkg::word encodeR(input isaPkg::funct fn, input isaPkg::regAddr rd,
                                           input isaPkg::regAddr rs, input isaPkg::regAddr rt,
                                           input logic [4:0] sa);
      return {6'h00, rs, rt, rd, sa, fn};
   endfunction

   function automatic isaPkg::word encodeJ(input logic [25:0] target);
      return {isaPkg::J, target};
   endfunction

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic checkValue(input string what, input isaPkg::word got,
                             input isaPkg::word expected);
      if (got !== expected) begin
         stopOnError($sformatf("ERROR at %0t ns: %s is 0x%h, expected 0x%h",
                               $time, what, got, expected));
      end
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   // Expected values worked out by hand from the ISA
   task automatic buildProgram();
      prog[0] = '{encodeI(isaPkg::ADDIU, 5'd1, 5'd0, 16'd5), 1'b1, 5'd1, 32'd5};
      // Forwarded r1 with a negative immediate
      prog[1] = '{encodeI(isaPkg::ADDIU, 5'd2, 5'd1, 16'hfffd), 1'b1, 5'd2, 32'd2};
      prog[2] = '{encodeI(isaPkg::LUI, 5'd3, 5'd0, 16'h1234), 1'b1, 5'd3, 32'h1234_0000};
      prog[3] = '{encodeI(isaPkg::ORI, 5'd3, 5'd3, 16'h5678), 1'b1, 5'd3, 32'h1234_5678};
      // Zero extended mask
      prog[4] = '{encodeI(isaPkg::ANDI, 5'd4, 5'd3, 16'h0ff0), 1'b1, 5'd4, 32'h0000_0670};
      prog[5] = '{encodeR(isaPkg::ADDU, 5'd5, 5'd1, 5'd2, 5'd0), 1'b1, 5'd5, 32'd7};
      prog[6] = '{encodeR(isaPkg::SUBU, 5'd6, 5'd2, 5'd1, 5'd0), 1'b1, 5'd6, 32'hffff_fffd};
      prog[7] = '{encodeR(isaPkg::AND, 5'd7, 5'd6, 5'd3, 5'd0), 1'b1, 5'd7, 32'h1234_5678};
      prog[8] = '{encodeR(isaPkg::OR, 5'd8, 5'd4, 5'd5, 5'd0), 1'b1, 5'd8, 32'h0000_0677};
      prog[9] = '{encodeR(isaPkg::XOR, 5'd9, 5'd3, 5'd8, 5'd0), 1'b1, 5'd9, 32'h1234_500f};
      // Signed compare of -3 against 5 both ways
      prog[10] = '{encodeR(isaPkg::SLT, 5'd10, 5'd6, 5'd1, 5'd0), 1'b1, 5'd10, 32'd1};
      prog[11] = '{encodeR(isaPkg::SLT, 5'd11, 5'd1, 5'd6, 5'd0), 1'b1, 5'd11, 32'd0};
      prog[12] = '{encodeR(isaPkg::SLL, 5'd12, 5'd0, 5'd1, 5'd4), 1'b1, 5'd12, 32'h50};
      prog[13] = '{encodeR(isaPkg::SRL, 5'd13, 5'd0, 5'd3, 5'd8), 1'b1, 5'd13, 32'h0012_3456};
      // Store to byte address 0x100, then read it back
      prog[14] = '{encodeI(isaPkg::SW, 5'd3, 5'd12, 16'h00b0), 1'b0, 5'd0, 32'd0};
      prog[15] = '{encodeI(isaPkg::ADDIU, 5'd14, 5'd0, 16'h002a), 1'b1, 5'd14, 32'h2a};
      prog[16] = '{encodeI(isaPkg::LW, 5'd15, 5'd12, 16'h00b0), 1'b1, 5'd15, 32'h1234_5678};
      // Loaded r15 used at once
      prog[17] = '{encodeR(isaPkg::ADDU, 5'd16, 5'd15, 5'd1, 5'd0), 1'b1, 5'd16, 32'h1234_567d};
      // Taken branch that lands on row 22
      prog[18] = '{encodeI(isaPkg::BEQ, 5'd3, 5'd15, 16'd3), 1'b0, 5'd0, 32'd0};
      prog[19] = '{encodeI(isaPkg::ADDIU, 5'd17, 5'd0, 16'h0011), 1'b1, 5'd17, 32'h11};
      // Skipped by the branch
      prog[20] = '{encodeI(isaPkg::ADDIU, 5'd18, 5'd0, 16'h0022), 1'b0, 5'd0, 32'd0};
      prog[21] = '{encodeI(isaPkg::ADDIU, 5'd17, 5'd0, 16'h0033), 1'b0, 5'd0, 32'd0};
      prog[22] = '{encodeI(isaPkg::ADDIU, 5'd19, 5'd0, 16'h0011), 1'b1, 5'd19, 32'h11};
      // Equal operands so it falls through
      prog[23] = '{encodeI(isaPkg::BNE, 5'd19, 5'd17, 16'd5), 1'b0, 5'd0, 32'd0};
      prog[24] = '{encodeR(isaPkg::SLL, 5'd20, 5'd0, 5'd17, 5'd2), 1'b1, 5'd20, 32'h44};
      prog[25] = '{encodeI(isaPkg::ADDIU, 5'd21, 5'd20, 16'd1), 1'b1, 5'd21, 32'h45};
      prog[26] = '{encodeJ(26'd29), 1'b0, 5'd0, 32'd0};
      prog[27] = '{encodeI(isaPkg::ADDIU, 5'd22, 5'd21, 16'h0100), 1'b1, 5'd22, 32'h145};
      prog[28] = '{encodeI(isaPkg::ADDIU, 5'd23, 5'd0, 16'h0099), 1'b0, 5'd0, 32'd0};
      // Final loop of a jump to self with a nop delay slot
      prog[29] = '{encodeJ(26'd29), 1'b0, 5'd0, 32'd0};
      prog[30] = '{32'h0000_0000, 1'b0, 5'd0, 32'd0};
   endtask

   // Host writes only while hold is high
   task automatic loadProgram();
      for (int row = 0; row < progLen; row++) begin
         nextCycle();
         hostWrite.valid = 1'b1;
         hostWrite.write = 1'b1;
         hostWrite.addr = row[corePkg::addrBits-1:0];
         hostWrite.data = prog[row].instr;
      end
      nextCycle();
      hostWrite = '0;
   endtask

   // One host write of a single word, only while hold is high
   task automatic writeHostWord(input logic [corePkg::addrBits-1:0] addr,
                                input isaPkg::word data);
      hostWrite.valid = 1'b1;
      hostWrite.write = 1'b1;
      hostWrite.addr = addr;
      hostWrite.data = data;
      nextCycle();
      hostWrite = '0;
   endtask

   task automatic waitRetire();
      int waited;
      waited = 0;
      @(negedge clk);
      while (retireOut.valid !== 1'b1) begin
         waited++;
         if (waited > retireTimeout) begin
            stopOnError("Timed out waiting for the next retire strobe");
         end
         @(negedge clk);
      end
   endtask

   // Every retire must match the next row that retires
   task automatic checkRetires(input string runName);
      for (int row = 0; row < progLen; row++) begin
         if (prog[row].retires) begin
            waitRetire();
            checkValue($sformatf("%s run row %0d register", runName, row),
                       {27'd0, retireOut.dest}, {27'd0, prog[row].dest});
            checkValue($sformatf("%s run row %0d data", runName, row),
                       retireOut.data, prog[row].value);
         end
      end
   endtask

   task automatic expectQuiet();
      repeat (quietCycles) begin
         @(negedge clk);
         if (retireOut.valid !== 1'b0) begin
            stopOnError($sformatf("Retire to r%0d seen inside the final jump loop",
                                  retireOut.dest));
         end
      end
   endtask

   // Random stalls until the checker is done
   task automatic pulseHold();
      int gap;
      int len;
      int pulses;
      pulses = 0;
      while (!runDone && (pulses < 100)) begin
         gap = $urandom_range(8, 1);
         len = $urandom_range(5, 1);
         repeat (gap) nextCycle();
         if (!runDone) begin
            hold = 1'b1;
            repeat (len) nextCycle();
            hold = 1'b0;
         end
         pulses++;
      end
   endtask

   // Stopped pipeline and bound assertions watched every cycle
   always @(negedge clk) begin
      if ((reset || hold) && (retireOut.valid !== 1'b0)) begin
         stopOnError("Retire strobe seen while reset or hold was high");
      end
      if (UUT.checks.failures != 0) begin
         stopOnError("A bound assertion on the DUT failed");
      end
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      hold = 1'b1;
      runDone = 1'b0;
      hostWrite = '0;
      void'($urandom(63));
      buildProgram();
      repeat (3) nextCycle();
      reset = 1'b0;
      loadProgram();
      nextCycle();
      hold = 1'b0;
      checkRetires("first");
      expectQuiet();

      // Second pass after reset on the program already in memory
      nextCycle();
      hold = 1'b1;
      reset = 1'b1;
      repeat (3) nextCycle();
      reset = 1'b0;
      // Old stored word overwritten so the second run has to store it again
      writeHostWord(10'h040, 32'hedcb_a987);
      nextCycle();
      hold = 1'b0;
      fork
         pulseHold();
         begin
            checkRetires("second");
            runDone = 1'b1;
         end
      join
      expectQuiet();

      if (UUT.checks.failures == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   end

endmodule

/* cpuTop.sv */
module cpuTop #(
   parameter int memWords = 1024
) (
   input  logic clk,
   input  logic reset,
   input  logic hold,
   input  corePkg::memRequest hostWrite,
   output corePkg::retire retireOut
);

   // Memory side
   corePkg::memRequest fetchReq;
   corePkg::memRequest dataReq;
   corePkg::memRequest memReq;
   corePkg::memResponse response;
   logic fetchGrant;
   logic dataGrant;

   // Fetch and decode
   logic instrValid;
   isaPkg::word instrPc;
   corePkg::decoded ctrl;
   isaPkg::regAddr rs;
   isaPkg::regAddr rt;
   isaPkg::word readDataA;
   isaPkg::word readDataB;

   // Execute and write-back
   logic redirect;
   isaPkg::word redirectPc;
   corePkg::wbBundle exToWb;
   corePkg::wbBundle forward;
   isaPkg::word forwardData;

   fetchUnit fetch (
      .clk(clk), .reset(reset), .hold(hold), .grant(fetchGrant),
      .redirect(redirect), .redirectPc(redirectPc),
      .request(fetchReq), .instrValid(instrValid), .instrPc(instrPc)
   );

   // Instruction word straight from the memory read register
   decodeUnit decode (
      .instr(response.data), .ctrl(ctrl), .rs(rs), .rt(rt)
   );

   regFile registers (
      .clk(clk), .writeEn(retireOut.valid), .writeAddr(retireOut.dest),
      .writeData(retireOut.data), .readAddrA(rs), .readAddrB(rt),
      .readDataA(readDataA), .readDataB(readDataB)
   );

   executeStage execute (
      .clk(clk), .reset(reset), .hold(hold), .instrValid(instrValid),
      .instrPc(instrPc), .ctrl(ctrl), .readDataA(readDataA), .readDataB(readDataB),
      .grant(dataGrant), .forward(forward), .forwardData(forwardData),
      .wbOut(exToWb), .request(dataReq), .redirect(redirect), .redirectPc(redirectPc)
   );

   memArbiter #(.memWords(memWords)) arbiter (
      .hostReq(hostWrite), .dataReq(dataReq), .fetchReq(fetchReq),
      .memReq(memReq), .dataGrant(dataGrant), .fetchGrant(fetchGrant)
   );

   sharedMemory #(.memWords(memWords)) memory (
      .clk(clk), .memReq(memReq), .response(response)
   );

   writebackStage writeback (
      .clk(clk), .reset(reset), .hold(hold), .wbIn(exToWb),
      .loadData(response.data), .forward(forward), .forwardData(forwardData),
      .regWrite(retireOut)
   );

endmodule

/* cpu_properties.sv */
module cpuProperties (
   input  logic clk,
   input  logic reset,
   input  logic hold,
   input  logic dataGrant,
   input  logic fetchGrant,
   input  logic instrValid,
   input  corePkg::retire retireOut
);

   timeunit 1ns;
   timeprecision 100ps;

   // Failed assertions so far, read by the testbench
   int failures = 0;

   // Arbiter hands out one grant at most
   grantsExclusive: assert property (@(posedge clk) !(dataGrant && fetchGrant))
      else begin
         $error("data and fetch grants both high");
         failures++;
      end

   // Nothing retires while reset or hold is high
   quietWhenStopped: assert property (@(posedge clk) (reset || hold) |-> !retireOut.valid)
      else begin
         $error("retire strobe during reset or hold");
         failures++;
      end

   // r0 writes never leave write-back
   noZeroRetire: assert property (@(posedge clk) disable iff (reset)
                                  retireOut.valid |-> (retireOut.dest != 5'd0))
      else begin
         $error("retire targets register zero");
         failures++;
      end

   // Data access steals the fetch slot, so a bubble follows
   dataGrantBubble: assert property (@(posedge clk) disable iff (reset)
                                     dataGrant |=> !instrValid)
      else begin
         $error("instruction valid right after a data grant");
         failures++;
      end

endmodule

bind cpuTop cpuProperties checks (
   .clk(clk), .reset(reset), .hold(hold), .dataGrant(dataGrant),
   .fetchGrant(fetchGrant), .instrValid(instrValid), .retireOut(retireOut)
);

/* decodeUnit.sv */
module decodeUnit (
   input  isaPkg::word instr,
   output corePkg::decoded ctrl,
   output isaPkg::regAddr rs,
   output isaPkg::regAddr rt
);

   logic signExt;

   // Register file read addresses
   assign rs = instr[25:21];
   assign rt = instr[20:16];

   always_comb begin
      // Start from a bubble, no write and no memory access
      ctrl = '0;
      signExt = 1'b0;
      ctrl.alu = isaPkg::aluAdd;
      ctrl.dest = instr[20:16];
      ctrl.shamt = instr[10:6];
      ctrl.target = instr[25:0];
      case (isaPkg::opcode'(instr[31:26]))
         isaPkg::SPECIAL: begin
            // R-type writes rd
            ctrl.dest = instr[15:11];
            ctrl.regWrite = 1'b1;
            case (isaPkg::funct'(instr[5:0]))
               isaPkg::ADDU: ctrl.alu = isaPkg::aluAdd;
               isaPkg::SUBU: ctrl.alu = isaPkg::aluSub;
               isaPkg::AND: ctrl.alu = isaPkg::aluAnd;
               isaPkg::OR: ctrl.alu = isaPkg::aluOr;
               isaPkg::XOR: ctrl.alu = isaPkg::aluXor;
               isaPkg::SLT: ctrl.alu = isaPkg::aluSlt;
               isaPkg::SLL: begin
                  ctrl.alu = isaPkg::aluSll;
                  ctrl.useShamt = 1'b1;
               end
               isaPkg::SRL: begin
                  ctrl.alu = isaPkg::aluSrl;
                  ctrl.useShamt = 1'b1;
               end
               default: ctrl.regWrite = 1'b0;
            endcase
         end
         isaPkg::ADDIU: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            signExt = 1'b1;
         end
         isaPkg::ANDI: begin
            ctrl.alu = isaPkg::aluAnd;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         isaPkg::ORI: begin
            ctrl.alu = isaPkg::aluOr;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         isaPkg::LUI: begin
            ctrl.alu = isaPkg::aluLui;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         // Address is rs plus signed offset
         isaPkg::LW: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.load = 1'b1;
            signExt = 1'b1;
         end
         isaPkg::SW: begin
            ctrl.useImm = 1'b1;
            ctrl.store = 1'b1;
            signExt = 1'b1;
         end
         isaPkg::BEQ: begin
            ctrl.beq = 1'b1;
            signExt = 1'b1;
         end
         isaPkg::BNE: begin
            ctrl.bne = 1'b1;
            signExt = 1'b1;
         end
         isaPkg::J: ctrl.jump = 1'b1;
         default: ctrl.regWrite = 1'b0;
      endcase
      // Logical immediates are zero extended
      ctrl.imm = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};
   end

endmodule

/* executeStage.sv */
module executeStage (
   input  logic clk,
   input  logic reset,
   input  logic hold,
   input  logic instrValid,
   input  isaPkg::word instrPc,
   input  corePkg::decoded ctrl,
   input  isaPkg::word readDataA,
   input  isaPkg::word readDataB,
   input  logic grant,
   input  corePkg::wbBundle forward,
   input  isaPkg::word forwardData,
   output corePkg::wbBundle wbOut,
   output corePkg::memRequest request,
   output logic redirect,
   output isaPkg::word redirectPc
);

   corePkg::execBundle ex;
   isaPkg::word opA;
   isaPkg::word opB;
   isaPkg::word srcA;
   isaPkg::word srcB;
   isaPkg::word result;
   isaPkg::word delayPc;
   isaPkg::word target;
   isaPkg::word pendingPc;
   logic taken;
   logic memOp;
   logic pending;

   // Write-back result wins when it targets this source
   function automatic isaPkg::word bypass(input isaPkg::regAddr src, input isaPkg::word value,
                                          input corePkg::wbBundle wb, input isaPkg::word wbData);
      if (wb.valid && (wb.dest != '0) && (wb.dest == src)) begin
         return wbData;
      end
      return value;
   endfunction

   // Pipeline register, payload kept without reset
   always_ff @(posedge clk) begin
      if (reset) begin
         ex.valid <= 1'b0;
      end else if (!hold) begin
         ex.valid <= instrValid;
         ex.ctrl <= ctrl;
         ex.opA <= readDataA;
         ex.opB <= readDataB;
         ex.pc <= instrPc;
      end
   end

   always_comb begin
      // rs and rt come from the raw target bits
      opA = bypass(ex.ctrl.target[25:21], ex.opA, forward, forwardData);
      opB = bypass(ex.ctrl.target[20:16], ex.opB, forward, forwardData);
      // Shifts take rt as B and shamt as A
      srcA = ex.ctrl.useShamt ? {27'd0, ex.ctrl.shamt} : opA;
      srcB = ex.ctrl.useImm ? ex.ctrl.imm : opB;
      case (ex.ctrl.alu)
         isaPkg::aluAdd: result = srcA + srcB;
         isaPkg::aluSub: result = srcA - srcB;
         isaPkg::aluAnd: result = srcA & srcB;
         isaPkg::aluOr: result = srcA | srcB;
         isaPkg::aluXor: result = srcA ^ srcB;
         isaPkg::aluSlt: result = {31'd0, $signed(srcA) < $signed(srcB)};
         isaPkg::aluSll: result = srcB << srcA[4:0];
         isaPkg::aluSrl: result = srcB >> srcA[4:0];
         isaPkg::aluLui: result = {srcB[15:0], 16'h0000};
         default: result = srcA + srcB;
      endcase
   end

   // Branch targets are relative to the delay slot
   assign delayPc = ex.pc + 32'd4;
   assign target = ex.ctrl.jump ? {delayPc[31:28], ex.ctrl.target, 2'b00}
                                : delayPc + {ex.ctrl.imm[29:0], 2'b00};
   assign taken = ex.valid && (ex.ctrl.jump || (ex.ctrl.beq && (opA == opB)) ||
                               (ex.ctrl.bne && (opA != opB)));

   // Delay slot not fetched yet, so park the target until it shows up
   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else if (!hold) begin
         if (taken && !instrValid) begin
            pending <= 1'b1;
            pendingPc <= target;
         end else if (instrValid) begin
            pending <= 1'b0;
         end
      end
   end

   // Redirect the fetch that follows the delay slot
   assign redirect = instrValid && (taken || pending);
   assign redirectPc = pending ? pendingPc : target;

   // Word access at the ALU address
   assign memOp = ex.ctrl.load || ex.ctrl.store;
   always_comb begin
      request.valid = ex.valid && memOp && !hold;
      request.addr = result[corePkg::addrBits+1:2];
      request.write = ex.ctrl.store;
      request.data = opB;
   end

   // A load that loses arbitration brings no data
   always_comb begin
      wbOut.valid = ex.valid && ex.ctrl.regWrite && (!ex.ctrl.load || grant);
      wbOut.dest = ex.ctrl.dest;
      wbOut.result = result;
      wbOut.load = ex.ctrl.load;
   end

endmodule

/* fetchUnit.sv */
module fetchUnit (
   input  logic clk,
   input  logic reset,
   input  logic hold,
   input  logic grant,
   input  logic redirect,
   input  isaPkg::word redirectPc,
   output corePkg::memRequest request,
   output logic instrValid,
   output isaPkg::word instrPc
);

   isaPkg::word pc;
   isaPkg::word fetchAddr;

   // Taken branch or jump replaces the sequential address
   assign fetchAddr = redirect ? redirectPc : pc;

   // Read-only requester, silent under hold
   always_comb begin
      request.valid = !hold;
      request.addr = fetchAddr[corePkg::addrBits+1:2];
      request.write = 1'b0;
      request.data = '0;
   end

   // Advance only past an address that memory accepted
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (grant) begin
         pc <= fetchAddr + 32'd4;
      end
   end

   // Word comes back next cycle
   // Under hold the flag stays and memory keeps the read word
   always_ff @(posedge clk) begin
      if (reset) begin
         instrValid <= 1'b0;
      end else if (!hold) begin
         instrValid <= grant;
      end
   end

   // Address paired with the word in flight
   always_ff @(posedge clk) begin
      if (grant) begin
         instrPc <= fetchAddr;
      end
   end

endmodule

/* isaPkg.sv */
package isaPkg;

   // Machine word and register index
   typedef logic [31:0] word;
   typedef logic [4:0] regAddr;

   // Primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      SPECIAL = 6'h00,
      J       = 6'h02,
      BEQ     = 6'h04,
      BNE     = 6'h05,
      ADDIU   = 6'h09,
      ANDI    = 6'h0c,
      ORI     = 6'h0d,
      LUI     = 6'h0f,
      LW      = 6'h23,
      SW      = 6'h2b
   } opcode;

   // Function codes under SPECIAL, instr[5:0]
   typedef enum logic [5:0] {
      SLL  = 6'h00,
      SRL  = 6'h02,
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      XOR  = 6'h26,
      SLT  = 6'h2a
   } funct;

   // Operations the execute ALU knows
   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluSlt,
      aluSll,
      aluSrl,
      aluLui
   } aluOp;

endpackage

/* memArbiter.sv */
module memArbiter #(
   parameter int memWords = 1024
) (
   input  corePkg::memRequest hostReq,
   input  corePkg::memRequest dataReq,
   input  corePkg::memRequest fetchReq,
   output corePkg::memRequest memReq,
   output logic dataGrant,
   output logic fetchGrant
);

   // Address bits the memory actually decodes
   localparam int usedBits = $clog2(memWords);

   corePkg::memRequest winner;

   // Host first, then data, fetch last
   assign dataGrant = dataReq.valid && !hostReq.valid;
   assign fetchGrant = fetchReq.valid && !hostReq.valid && !dataReq.valid;

   always_comb begin
      if (hostReq.valid) begin
         winner = hostReq;
      end else if (dataReq.valid) begin
         winner = dataReq;
      end else begin
         // Invalid when fetch is idle too
         winner = fetchReq;
      end
   end

   // Upper address bits dropped
   always_comb begin
      memReq = winner;
      memReq.addr = '0;
      memReq.addr[usedBits-1:0] = winner.addr[usedBits-1:0];
   end

endmodule

/* regFile.sv */
module regFile (
   input  logic clk,
   input  logic writeEn,
   input  isaPkg::regAddr writeAddr,
   input  isaPkg::word writeData,
   input  isaPkg::regAddr readAddrA,
   input  isaPkg::regAddr readAddrB,
   output isaPkg::word readDataA,
   output isaPkg::word readDataB
);

   isaPkg::word regs [32];

   // One read port, r0 is hardwired and a same-cycle write passes through
   function automatic isaPkg::word readPort(input isaPkg::regAddr addr);
      if (addr == '0) begin
         return '0;
      end else if (writeEn && (writeAddr == addr)) begin
         return writeData;
      end
      return regs[addr];
   endfunction

   always_ff @(posedge clk) begin
      if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   always_comb begin
      readDataA = readPort(readAddrA);
      readDataB = readPort(readAddrB);
   end

endmodule

/* sharedMemory.sv */
module sharedMemory #(
   parameter int memWords = 1024
) (
   input  logic clk,
   input  corePkg::memRequest memReq,
   output corePkg::memResponse response
);

   localparam int usedBits = $clog2(memWords);

   isaPkg::word mem [memWords];
   logic [usedBits-1:0] index;

   assign index = memReq.addr[usedBits-1:0];

   // Reads update the output word, writes leave it alone
   // so a pending word survives host writes
   always_ff @(posedge clk) begin
      if (memReq.valid) begin
         if (memReq.write) begin
            mem[index] <= memReq.data;
         end else begin
            response.data <= mem[index];
         end
      end
   end

endmodule

/* src.f */
isaPkg.sv
corePkg.sv
fetchUnit.sv
decodeUnit.sv
regFile.sv
executeStage.sv
memArbiter.sv
sharedMemory.sv
writebackStage.sv
cpuTop.sv
cpu_properties.sv
cpuTb.sv

/* writebackStage.sv */
module writebackStage (
   input  logic clk,
   input  logic reset,
   input  logic hold,
   input  corePkg::wbBundle wbIn,
   input  isaPkg::word loadData,
   output corePkg::wbBundle forward,
   output isaPkg::word forwardData,
   output corePkg::retire regWrite
);

   corePkg::wbBundle stage;

   always_ff @(posedge clk) begin
      if (reset) begin
         stage.valid <= 1'b0;
      end else if (!hold) begin
         stage <= wbIn;
      end
   end

   // Load data arrives this cycle from memory
   assign forwardData = stage.load ? loadData : stage.result;
   assign forward = stage;

   // r0 never written, nothing retires under hold
   always_comb begin
      regWrite.valid = stage.valid && (stage.dest != '0) && !hold;
      regWrite.dest = stage.dest;
      regWrite.data = forwardData;
   end

endmodule
